// ==== logic/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // ====================================================================
    // Instruction fields
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;

    localparam reg_addr_t LINK_REG = 5'd31;

    // ====================================================================
    // Primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LWL     = 6'b100010;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_LWR     = 6'b100110;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SWL     = 6'b101010;
    localparam opcode_t OP_SW      = 6'b101011;
    localparam opcode_t OP_SWR     = 6'b101110;

    // R-type function codes.
    localparam func_t F_SLL  = 6'b000000;
    localparam func_t F_SRL  = 6'b000010;
    localparam func_t F_SRA  = 6'b000011;
    localparam func_t F_SLLV = 6'b000100;
    localparam func_t F_SRLV = 6'b000110;
    localparam func_t F_SRAV = 6'b000111;
    localparam func_t F_JR   = 6'b001000;
    localparam func_t F_JALR = 6'b001001;
    localparam func_t F_MOVZ = 6'b001010;
    localparam func_t F_MOVN = 6'b001011;
    localparam func_t F_SYNC = 6'b001111;
    localparam func_t F_ADD  = 6'b100000;
    localparam func_t F_ADDU = 6'b100001;
    localparam func_t F_SUB  = 6'b100010;
    localparam func_t F_SUBU = 6'b100011;
    localparam func_t F_AND  = 6'b100100;
    localparam func_t F_OR   = 6'b100101;
    localparam func_t F_XOR  = 6'b100110;
    localparam func_t F_NOR  = 6'b100111;
    localparam func_t F_SLT  = 6'b101010;
    localparam func_t F_SLTU = 6'b101011;

    // REGIMM sub-codes, carried in rt.
    localparam reg_addr_t B_BLTZ   = 5'b00000;
    localparam reg_addr_t B_BGEZ   = 5'b00001;
    localparam reg_addr_t B_BLTZAL = 5'b10000;
    localparam reg_addr_t B_BGEZAL = 5'b10001;

    // ====================================================================
    // Code sets
    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_PASSA, ALU_MOVZ, ALU_MOVN
    } alu_func_t;

    typedef enum logic {REGB, IMM} alu_src_t;

    typedef enum logic [2:0] {T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ} branch_type_t;

    typedef enum logic [5:0] {
        NOP, ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV, MOVZ, MOVN, LUI, JR, JALR,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ, J, JAL,
        LB, LBU, LH, LHU, LW, LWL, LWR, SB, SH, SW, SWL, SWR,
        RESERVED
    } decoded_op_t;                                  // NOP is the all-zero code.

    typedef enum logic [1:0] {SPECIAL, BRANCH, IMMEDIATE, NONE} op_group_t;

    typedef struct packed {
        alu_func_t    alufunc;
        alu_src_t     alusrc;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        logic         zeroext;                       // Zero-extend the immediate.
        logic         shamt_valid;                   // Shift amount from instr[10:6].
        logic         branch;
        branch_type_t branch_type;
        logic         jump;
        logic         jr;                            // Jump target from rs.
        logic         is_link;
    } control_t;

    typedef struct packed {
        decoded_op_t op;
        control_t    ctl;
        reg_addr_t   srca;
        reg_addr_t   srcb;
        reg_addr_t   dest;
        logic        reserved;
    } decode_t;

    function automatic decode_t reserved_dec();
        decode_t d;
        d = '0;
        d.op = RESERVED;
        d.ctl.alufunc = ALU_PASSA;
        d.reserved = 1'b1;
        return d;
    endfunction

    // Return address goes to r31.
    function automatic decode_t with_link(input decode_t d);
        d.ctl.regwrite = 1'b1;
        d.ctl.is_link = 1'b1;
        d.dest = LINK_REG;
        return d;
    endfunction

endpackage

`default_nettype wire

// ==== logic/special_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module special_decode import decode_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  reg_addr_t rd,
    input  func_t     func,
    output decode_t   result
);

    function automatic decode_t alu_rec(input decoded_op_t op, input alu_func_t fn,
                                        input reg_addr_t a, input reg_addr_t b,
                                        input reg_addr_t d, input logic fixed);
        decode_t r;
        r = '0;
        r.op = op;
        r.ctl.alufunc = fn;
        r.ctl.alusrc = REGB;
        r.ctl.regwrite = 1'b1;
        r.ctl.shamt_valid = fixed;
        r.srca = fixed ? 5'd0 : a;                   // Fixed shifts take shamt, not rs.
        r.srcb = b;
        r.dest = d;
        return r;
    endfunction

    always_comb begin
        result = '0;
        case (func)
            F_ADD:  result = alu_rec(ADD, ALU_ADD, rs, rt, rd, 1'b0);
            F_ADDU: result = alu_rec(ADDU, ALU_ADDU, rs, rt, rd, 1'b0);
            F_SUB:  result = alu_rec(SUB, ALU_SUB, rs, rt, rd, 1'b0);
            F_SUBU: result = alu_rec(SUBU, ALU_SUBU, rs, rt, rd, 1'b0);
            F_SLT:  result = alu_rec(SLT, ALU_SLT, rs, rt, rd, 1'b0);
            F_SLTU: result = alu_rec(SLTU, ALU_SLTU, rs, rt, rd, 1'b0);
            F_AND:  result = alu_rec(AND, ALU_AND, rs, rt, rd, 1'b0);
            F_OR:   result = alu_rec(OR, ALU_OR, rs, rt, rd, 1'b0);
            F_XOR:  result = alu_rec(XOR, ALU_XOR, rs, rt, rd, 1'b0);
            F_NOR:  result = alu_rec(NOR, ALU_NOR, rs, rt, rd, 1'b0);
            F_SLLV: result = alu_rec(SLLV, ALU_SLL, rs, rt, rd, 1'b0);
            F_SRLV: result = alu_rec(SRLV, ALU_SRL, rs, rt, rd, 1'b0);
            F_SRAV: result = alu_rec(SRAV, ALU_SRA, rs, rt, rd, 1'b0);
            F_SLL:  result = alu_rec(SLL, ALU_SLL, rs, rt, rd, 1'b1);
            F_SRL:  result = alu_rec(SRL, ALU_SRL, rs, rt, rd, 1'b1);
            F_SRA:  result = alu_rec(SRA, ALU_SRA, rs, rt, rd, 1'b1);
            F_MOVZ: result = alu_rec(MOVZ, ALU_MOVZ, rs, rt, rd, 1'b0);
            F_MOVN: result = alu_rec(MOVN, ALU_MOVN, rs, rt, rd, 1'b0);
            F_JR, F_JALR: begin
                result.op = JR;
                result.ctl.alufunc = ALU_PASSA;
                result.ctl.jump = 1'b1;
                result.ctl.jr = 1'b1;
                result.srca = rs;
                if (func == F_JALR) begin
                    result = with_link(result);
                    result.op = JALR;
                end
            end
            F_SYNC: result.op = NOP;                 // No ordering needed in-order.
            default: result = reserved_dec();
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/branch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_decode import decode_pkg::*; (
    input  opcode_t   opcode,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output decode_t   result
);

    function automatic decode_t branch_rec(input decoded_op_t op, input branch_type_t bt,
                                           input reg_addr_t a, input reg_addr_t b);
        decode_t r;
        r = '0;
        r.op = op;
        r.ctl.branch = 1'b1;
        r.ctl.branch_type = bt;
        r.srca = a;
        r.srcb = b;
        return r;
    endfunction

    always_comb begin
        result = '0;
        case (opcode)
            OP_BEQ:  result = branch_rec(BEQ, T_BEQ, rs, rt);
            OP_BNE:  result = branch_rec(BNE, T_BNE, rs, rt);
            OP_BGTZ: result = branch_rec(BGTZ, T_BGTZ, rs, 5'd0);
            OP_BLEZ: result = branch_rec(BLEZ, T_BLEZ, rs, 5'd0);
            OP_REGIMM: begin
                case (rt)                            // Sub-code sits in the rt field.
                    B_BLTZ:   result = branch_rec(BLTZ, T_BLTZ, rs, 5'd0);
                    B_BGEZ:   result = branch_rec(BGEZ, T_BGEZ, rs, 5'd0);
                    B_BLTZAL: result = with_link(branch_rec(BLTZAL, T_BLTZ, rs, 5'd0));
                    B_BGEZAL: result = with_link(branch_rec(BGEZAL, T_BGEZ, rs, 5'd0));
                    default:  result = reserved_dec();
                endcase
            end
            OP_J, OP_JAL: begin
                result.op = J;
                result.ctl.jump = 1'b1;              // Target from instr[25:0].
                if (opcode == OP_JAL) begin
                    result = with_link(result);
                    result.op = JAL;
                end
            end
            default: result = reserved_dec();
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/imm_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_decode import decode_pkg::*; (
    input  opcode_t   opcode,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output decode_t   result
);

    function automatic decode_t alu_imm(input decoded_op_t op, input alu_func_t fn,
                                        input reg_addr_t a, input reg_addr_t d,
                                        input logic zext);
        decode_t r;
        r = '0;
        r.op = op;
        r.ctl.alufunc = fn;
        r.ctl.alusrc = IMM;
        r.ctl.regwrite = 1'b1;
        r.ctl.zeroext = zext;
        r.srca = a;
        r.dest = d;
        return r;
    endfunction

    // Address is rs plus the sign-extended offset.
    function automatic decode_t mem_rec(input decoded_op_t op, input logic store,
                                        input reg_addr_t a, input reg_addr_t b);
        decode_t r;
        r = '0;
        r.op = op;
        r.ctl.alufunc = ALU_ADD;
        r.ctl.alusrc = IMM;
        r.ctl.regwrite = !store;
        r.ctl.memtoreg = !store;
        r.ctl.memwrite = store;
        r.srca = a;
        r.srcb = store ? b : 5'd0;                   // Store data comes from rt.
        r.dest = store ? 5'd0 : b;
        return r;
    endfunction

    always_comb begin
        case (opcode)
            OP_ADDI:  result = alu_imm(ADD, ALU_ADD, rs, rt, 1'b0);
            OP_ADDIU: result = alu_imm(ADDU, ALU_ADDU, rs, rt, 1'b0);
            OP_SLTI:  result = alu_imm(SLT, ALU_SLT, rs, rt, 1'b0);
            OP_SLTIU: result = alu_imm(SLTU, ALU_SLTU, rs, rt, 1'b0);
            OP_ANDI:  result = alu_imm(AND, ALU_AND, rs, rt, 1'b1);
            OP_ORI:   result = alu_imm(OR, ALU_OR, rs, rt, 1'b1);
            OP_XORI:  result = alu_imm(XOR, ALU_XOR, rs, rt, 1'b1);
            OP_LUI:   result = alu_imm(LUI, ALU_LUI, 5'd0, rt, 1'b0);
            OP_LB:    result = mem_rec(LB, 1'b0, rs, rt);
            OP_LBU:   result = mem_rec(LBU, 1'b0, rs, rt);
            OP_LH:    result = mem_rec(LH, 1'b0, rs, rt);
            OP_LHU:   result = mem_rec(LHU, 1'b0, rs, rt);
            OP_LW:    result = mem_rec(LW, 1'b0, rs, rt);
            OP_LWL:   result = mem_rec(LWL, 1'b0, rs, rt);
            OP_LWR:   result = mem_rec(LWR, 1'b0, rs, rt);
            OP_SB:    result = mem_rec(SB, 1'b1, rs, rt);
            OP_SH:    result = mem_rec(SH, 1'b1, rs, rt);
            OP_SW:    result = mem_rec(SW, 1'b1, rs, rt);
            OP_SWL:   result = mem_rec(SWL, 1'b1, rs, rt);
            OP_SWR:   result = mem_rec(SWR, 1'b1, rs, rt);
            default:  result = reserved_dec();
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/main_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_decode import decode_pkg::*; (
    input  word_t   instr,
    output decode_t dec
);

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    func_t     func;
    op_group_t group;
    decode_t   special_dec;
    decode_t   branch_dec;
    decode_t   imm_dec;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign func   = instr[5:0];

    special_decode special_i (.rs(rs), .rt(rt), .rd(rd), .func(func), .result(special_dec));

    branch_decode branch_i (.opcode(opcode), .rs(rs), .rt(rt), .result(branch_dec));

    imm_decode imm_i (.opcode(opcode), .rs(rs), .rt(rt), .result(imm_dec));

    // ====================================================================
    // Group by opcode row; holes inside a row are flagged by the sub-decoder
    always_comb begin
        casez (opcode)
            OP_SPECIAL: group = SPECIAL;
            6'b000???:  group = BRANCH;              // REGIMM, jumps and branches.
            6'b001???:  group = IMMEDIATE;
            6'b10????:  group = IMMEDIATE;           // Loads and stores.
            default:    group = NONE;
        endcase
    end

    always_comb begin
        case (group)
            SPECIAL:   dec = special_dec;
            BRANCH:    dec = branch_dec;
            IMMEDIATE: dec = imm_dec;
            default:   dec = reserved_dec();
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  word_t   instr,
    output logic    out_valid,
    output decode_t dec
);

    decode_t dec_comb;

    main_decode decoder_i (
        .instr(instr),
        .dec  (dec_comb)
    );

    // ====================================================================
    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            dec       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                dec <= dec_comb;                     // Holds between strobes.
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/decode_stage_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva import decode_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    in_valid,
    input logic    out_valid,
    input decode_t dec
);

    // ====================================================================
    // Output register timing and record sanity
    valid_delay_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by exactly one cycle");

    reserved_a: assert property (@(posedge clk) disable iff (!rst_n)
        dec.reserved |-> !dec.ctl.regwrite && !dec.ctl.memwrite)
        else $error("Reserved instruction carries a register or memory write");

    link_a: assert property (@(posedge clk) disable iff (!rst_n)
        dec.ctl.is_link |-> dec.dest == LINK_REG)
        else $error("Link instruction does not write register 31");

endmodule

bind decode_stage decode_stage_sva sva_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .dec      (dec)
);

`default_nettype wire

// ==== tb/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import decode_pkg::*; ();

    localparam int         RST_CYCLES = 8;
    localparam logic [1:0] D_NONE     = 2'd0;        // Destination rules.
    localparam logic [1:0] D_RT       = 2'd1;
    localparam logic [1:0] D_RD       = 2'd2;
    localparam logic [1:0] D_LINK     = 2'd3;

    typedef struct packed {
        opcode_t     opc;
        logic [5:0]  code;                           // Function, or rt for REGIMM.
        decoded_op_t op;
        control_t    ctl;
        logic [1:0]  src;                            // {srca is rs, srcb is rt}.
        logic [1:0]  dr;
    } vec_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    word_t   instr;
    logic    out_valid;
    decode_t dec;

    vec_t    vecs[$];
    decode_t exp_q[$];
    int      due_q[$];
    decode_t last;
    int      cycle;
    int      checked;
    int      errors;

    decode_stage dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .out_valid(out_valid),
        .dec      (dec)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // Flag bits run from alusrc down to is_link in control_t order.
    task automatic push_vec(input opcode_t opc, input logic [5:0] code, input decoded_op_t op,
                            input alu_func_t fn, input logic [9:0] fl, input branch_type_t bt,
                            input logic [1:0] src, input logic [1:0] dr);
        vec_t v;
        v = '0;
        v.opc = opc;
        v.code = code;
        v.op = op;
        v.ctl.alufunc = fn;
        v.ctl.branch_type = bt;
        v.ctl.alusrc = alu_src_t'(fl[9]);
        {v.ctl.regwrite, v.ctl.memtoreg, v.ctl.memwrite, v.ctl.zeroext,
         v.ctl.shamt_valid, v.ctl.branch, v.ctl.jump, v.ctl.jr, v.ctl.is_link} = fl[8:0];
        v.src = src;
        v.dr = dr;
        vecs.push_back(v);
    endtask

    // ====================================================================
    // Stimulus table
    task automatic load_table();
        push_vec(OP_SPECIAL, F_ADD, ADD, ALU_ADD, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_SUBU, SUBU, ALU_SUBU, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_SLT, SLT, ALU_SLT, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_NOR, NOR, ALU_NOR, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_SLLV, SLLV, ALU_SLL, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_SLL, SLL, ALU_SLL, 10'b0100010000, T_BEQ, 2'b01, D_RD);
        push_vec(OP_SPECIAL, F_SRA, SRA, ALU_SRA, 10'b0100010000, T_BEQ, 2'b01, D_RD);
        push_vec(OP_SPECIAL, F_MOVZ, MOVZ, ALU_MOVZ, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_MOVN, MOVN, ALU_MOVN, 10'b0100000000, T_BEQ, 2'b11, D_RD);
        push_vec(OP_SPECIAL, F_JR, JR, ALU_PASSA, 10'b0000000110, T_BEQ, 2'b10, D_NONE);
        push_vec(OP_SPECIAL, F_JALR, JALR, ALU_PASSA, 10'b0100000111, T_BEQ, 2'b10, D_LINK);
        push_vec(OP_SPECIAL, F_SYNC, NOP, ALU_ADD, 10'b0000000000, T_BEQ, 2'b00, D_NONE);
        push_vec(OP_SPECIAL, 6'b011000, RESERVED, ALU_PASSA, 10'b0, T_BEQ, 2'b00, D_NONE);
        push_vec(OP_REGIMM, 6'(B_BLTZ), BLTZ, ALU_ADD, 10'b0000001000, T_BLTZ, 2'b10, D_NONE);
        push_vec(OP_REGIMM, 6'(B_BGEZ), BGEZ, ALU_ADD, 10'b0000001000, T_BGEZ, 2'b10, D_NONE);
        push_vec(OP_REGIMM, 6'(B_BLTZAL), BLTZAL, ALU_ADD, 10'b0100001001, T_BLTZ, 2'b10, D_LINK);
        push_vec(OP_REGIMM, 6'(B_BGEZAL), BGEZAL, ALU_ADD, 10'b0100001001, T_BGEZ, 2'b10, D_LINK);
        push_vec(OP_REGIMM, 6'b000010, RESERVED, ALU_PASSA, 10'b0, T_BEQ, 2'b00, D_NONE);
        push_vec(OP_BEQ, 6'd0, BEQ, ALU_ADD, 10'b0000001000, T_BEQ, 2'b11, D_NONE);
        push_vec(OP_BNE, 6'd0, BNE, ALU_ADD, 10'b0000001000, T_BNE, 2'b11, D_NONE);
        push_vec(OP_BGTZ, 6'd0, BGTZ, ALU_ADD, 10'b0000001000, T_BGTZ, 2'b10, D_NONE);
        push_vec(OP_BLEZ, 6'd0, BLEZ, ALU_ADD, 10'b0000001000, T_BLEZ, 2'b10, D_NONE);
        push_vec(OP_J, 6'd0, J, ALU_ADD, 10'b0000000100, T_BEQ, 2'b00, D_NONE);
        push_vec(OP_JAL, 6'd0, JAL, ALU_ADD, 10'b0100000101, T_BEQ, 2'b00, D_LINK);
        push_vec(OP_ADDI, 6'd0, ADD, ALU_ADD, 10'b1100000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_SLTIU, 6'd0, SLTU, ALU_SLTU, 10'b1100000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_ANDI, 6'd0, AND, ALU_AND, 10'b1100100000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_ORI, 6'd0, OR, ALU_OR, 10'b1100100000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_XORI, 6'd0, XOR, ALU_XOR, 10'b1100100000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_LUI, 6'd0, LUI, ALU_LUI, 10'b1100000000, T_BEQ, 2'b00, D_RT);
        push_vec(OP_LB, 6'd0, LB, ALU_ADD, 10'b1110000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_LHU, 6'd0, LHU, ALU_ADD, 10'b1110000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_LW, 6'd0, LW, ALU_ADD, 10'b1110000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_LWL, 6'd0, LWL, ALU_ADD, 10'b1110000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_LWR, 6'd0, LWR, ALU_ADD, 10'b1110000000, T_BEQ, 2'b10, D_RT);
        push_vec(OP_SB, 6'd0, SB, ALU_ADD, 10'b1001000000, T_BEQ, 2'b11, D_NONE);
        push_vec(OP_SW, 6'd0, SW, ALU_ADD, 10'b1001000000, T_BEQ, 2'b11, D_NONE);
        push_vec(OP_SWR, 6'd0, SWR, ALU_ADD, 10'b1001000000, T_BEQ, 2'b11, D_NONE);
        push_vec(6'b010000, 6'd0, RESERVED, ALU_PASSA, 10'b0, T_BEQ, 2'b00, D_NONE);
        push_vec(6'b011100, 6'd0, RESERVED, ALU_PASSA, 10'b0, T_BEQ, 2'b00, D_NONE);
        push_vec(6'b110000, 6'd0, RESERVED, ALU_PASSA, 10'b0, T_BEQ, 2'b00, D_NONE);
        push_vec(6'b101111, 6'd0, RESERVED, ALU_PASSA, 10'b0, T_BEQ, 2'b00, D_NONE);
    endtask

    function automatic word_t make_instr(input vec_t v, input word_t rnd);
        word_t w;
        w = {v.opc, rnd[25:0]};
        if (v.opc == OP_SPECIAL) w[5:0] = v.code;
        if (v.opc == OP_REGIMM) w[20:16] = v.code[4:0];
        return w;
    endfunction

    function automatic decode_t expect_rec(input vec_t v, input word_t w);
        decode_t e;
        e = '0;
        e.op = v.op;
        e.ctl = v.ctl;
        e.srca = v.src[1] ? w[25:21] : 5'd0;
        e.srcb = v.src[0] ? w[20:16] : 5'd0;
        case (v.dr)
            D_RT:    e.dest = w[20:16];
            D_RD:    e.dest = w[15:11];
            D_LINK:  e.dest = 5'd31;
            default: e.dest = 5'd0;
        endcase
        e.reserved = (v.op == RESERVED);
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // ====================================================================
    // Result checker on the falling edge
    always @(negedge clk) begin
        decode_t e;
        int      due;
        if (rst_n) begin
            if (out_valid && exp_q.size() == 0) begin
                $display("out_valid pulsed at %0t with no instruction outstanding", $time);
                errors++;
            end else if (out_valid) begin
                e = exp_q.pop_front();
                due = due_q.pop_front();
                if (cycle != due) begin
                    $display("Result at %0t came in cycle %0d, not %0d", $time, cycle, due);
                    errors++;
                end
                check_val("dec.op", 32'(e.op), 32'(dec.op));
                check_val("dec.ctl", 32'(e.ctl), 32'(dec.ctl));
                check_val("dec.srca", 32'(e.srca), 32'(dec.srca));
                check_val("dec.srcb", 32'(e.srcb), 32'(dec.srcb));
                check_val("dec.dest", 32'(e.dest), 32'(dec.dest));
                check_val("dec.reserved", 32'(e.reserved), 32'(dec.reserved));
                last = e;
                checked++;
            end else if (dec !== last) begin
                $display("ERR %0t dec expected %h got %h", $time, last, dec);  // Must hold.
                errors++;
            end
        end
    end

    initial begin
        word_t w;
        int    gap;
        void'($urandom(32'h6d30_682c));
        rst_n = 1'b0;
        in_valid = 1'b0;
        instr = '0;
        last = '0;
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);                   // Two idle cycles before the first strobe.
        for (int i = 0; i < vecs.size(); i++) begin
            gap = (i < 4) ? 0 : int'($urandom_range(2, 0));
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
                instr <= $urandom;
            end
            @(posedge clk);
            w = make_instr(vecs[i], $urandom);
            in_valid <= 1'b1;
            instr <= w;
            exp_q.push_back(expect_rec(vecs[i], w));
            due_q.push_back(cycle + 2);              // Loaded on the next edge and seen after it.
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (checked < vecs.size()) @(negedge clk);
        repeat (3) @(negedge clk);
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ====================================================================
    // Watchdog
    initial begin
        int limit;
        #1;
        limit = (RST_CYCLES + 3 * vecs.size() + 20) * 8;
        #(limit - 1);
        $display("Timeout: only %0d of %0d results came back", checked, vecs.size());
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/decode_pkg.sv
logic/special_decode.sv
logic/branch_decode.sv
logic/imm_decode.sv
logic/main_decode.sv
logic/decode_stage.sv
tb/decode_stage_sva.sv
tb/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_decode_stage \
    -o sim_decode_stage > build.log 2>&1 \
    && ./obj_dir/sim_decode_stage > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run of the simulation failed"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log || exit 1
exit 0
